/* project.f */
+incdir+include
verilog/tetris_cmd_pkg.sv
verilog/tetris_piece_pkg.sv
verilog/tetris_ctrl.sv
verilog/piece_move.sv
verilog/board_store.sv
verilog/bcd_score.sv
verilog/tetris_top.sv
test/tetris_checker.sv
test/tb_tetris.sv

/* run.sh */
#!/bin/bash
# build and run the tetris core testbench with Verilator
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_tetris -o sim_tetris
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tetris > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* test/tb_tetris.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module tb_tetris import tetris_cmd_pkg::*, tetris_piece_pkg::*; ();

  localparam int RANDOM_CMDS = 2000;
  localparam int DIRECTED_CMDS = 600;
  localparam int CMD_LIMIT = 300;  // cycles allowed per command
  localparam int READS = 6;
  localparam longint WATCHDOG_NS =
    longint'(RANDOM_CMDS + DIRECTED_CMDS) * (CMD_LIMIT + READS + 2) * 10 + 5 * 210 * 10 + 10000;

  logic       clk;
  logic       reset_n;
  state_t     ctrl;
  logic [3:0] x;
  logic [4:0] y;
  state_t     state;
  logic [4*`TETRIS_SCORE_DIGITS-1:0] score;
  kind_t      kind;
  kind_t      hold;
  kind_t [`TETRIS_PREVIEW-1:0] next;
  logic [15:0] lfsr;
  logic       stuck;
  state_t     last_cmd;
  int         i;

  tetris_top dut0 (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .x       (x),
    .y       (y),
    .state   (state),
    .score   (score),
    .kind    (kind),
    .hold    (hold),
    .next    (next)
  );

  tetris_checker chk0 (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .x       (x),
    .y       (y),
    .state   (state),
    .score   (score),
    .kind    (kind),
    .hold    (hold),
    .next    (next)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    logic b;
    v = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
      v = {v[14:0], b};
    end
    return v;
  endfunction

  function automatic state_t pick_cmd();
    logic [3:0] v;
    v = 4'(rand_bits(4));
    case (v)
      4'd7, 4'd8:   return LEFT;
      4'd9, 4'd10:  return RIGHT;
      4'd11:        return ROTATE;
      4'd12:        return ROTATE_REV;
      4'd13, 4'd14: return DOWN;
      4'd15:        return HOLD;
      default:      return DROP;  // weighted toward drops
    endcase
  endfunction

  task automatic send_cmd(state_t c);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    last_cmd = c;
    @(posedge clk);
    ctrl <= c;
    @(posedge clk);
    ctrl <= NONE;
    while (!done) begin
      @(posedge clk);
      if (state == WAIT || state == END) begin
        done = 1'b1;
      end else begin
        n++;
        if (n >= CMD_LIMIT)
          stuck = 1'b1;
      end
    end
    repeat (READS) begin
      @(posedge clk);
      x <= 4'(rand_bits(4));
      y <= 5'(rand_bits(5));
    end
  endtask

  task automatic scan_board();
    for (int yy = 0; yy < `TETRIS_H; yy++)
      for (int xx = 0; xx < `TETRIS_W; xx++) begin
        @(posedge clk);
        x <= 4'(xx);
        y <= 5'(yy);
      end
    repeat (2) @(posedge clk);
    @(negedge clk);  // last cell compared
  endtask

  initial begin : cmd_watch
    wait (stuck);
    $display("command %s did not return to WAIT or END within %0d cycles",
             last_cmd.name(), CMD_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    reset_n = 1'b1;
    ctrl = NONE;
    x = '0;
    y = '0;
    lfsr = 16'd87;
    stuck = 1'b0;
    last_cmd = NONE;
    repeat (16) @(posedge clk);
    reset_n <= 1'b0;

    send_cmd(LEFT);  // only starts the game
    scan_board();
    chk0.report_test("reset_start");

    repeat (6) send_cmd(LEFT);
    repeat (9) send_cmd(RIGHT);
    repeat (2) send_cmd(ROTATE);
    send_cmd(ROTATE_REV);
    repeat (3) send_cmd(DOWN);
    send_cmd(DROP);
    send_cmd(ROTATE);
    repeat (22) send_cmd(DOWN);  // runs into the first piece
    repeat (5) send_cmd(LEFT);
    send_cmd(DROP);
    scan_board();
    chk0.report_test("moves");

    send_cmd(HOLD);
    send_cmd(LEFT);
    send_cmd(HOLD);
    send_cmd(HOLD);
    send_cmd(DROP);
    send_cmd(HOLD);
    send_cmd(ROTATE);
    send_cmd(HOLD);
    repeat (4) send_cmd(LEFT);
    send_cmd(HOLD);
    send_cmd(DROP);
    scan_board();
    chk0.report_test("hold");

    for (i = 0; i < 40; i++) begin
      repeat (i % 4) send_cmd(ROTATE);
      repeat (5) send_cmd(LEFT);
      repeat (i % 10) send_cmd(RIGHT);
      send_cmd(DROP);
    end
    scan_board();
    chk0.report_test("drop_clear");

    repeat (RANDOM_CMDS) send_cmd(pick_cmd());
    scan_board();
    chk0.report_test("random");

    chk0.report_totals();
    if (chk0.errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* test/tetris_checker.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module tetris_checker import tetris_cmd_pkg::*, tetris_piece_pkg::*; (
  input logic       clk,
  input logic       reset_n,
  input state_t     ctrl,
  input logic [3:0] x,
  input logic [4:0] y,
  input state_t     state,
  input logic [4*`TETRIS_SCORE_DIGITS-1:0] score,
  input kind_t      kind,
  input kind_t      hold,
  input kind_t [`TETRIS_PREVIEW-1:0] next
);

  localparam int W = `TETRIS_W;
  localparam int H = `TETRIS_H;
  localparam int HID = `TETRIS_HIDDEN;

  kind_t      board [H][W];  // placed kinds with row 0 as the top visible row
  kind_t      m_kind;
  kind_t      m_hold;
  int         m_rot;
  int         m_x;
  int         m_y;
  int         m_lines;
  logic       m_over;
  logic       m_live;
  state_t     pend;
  logic       have_pend;
  logic       rd_stable;
  logic [3:0] rd_x;
  logic [4:0] rd_y;
  state_t     last_state;
  state_t     acc_first;  // first state after an accepted command
  int         acc_step;
  state_t     exp_st;
  int         checks = 0;
  int         errors = 0;
  int         test_checks = 0;
  int         test_errors = 0;

  function automatic kind_t kind_after(kind_t k);
    return kind_t'(3'((int'(k) % 7) + 1));  // I follows Z and EMPTY
  endfunction

  function automatic logic cell_on(kind_t k, int rot, int r, int c);
    logic [15:0] s;
    s = SHAPE[k][rot];
    return s[15 - 4*r - c];
  endfunction

  function automatic logic fits(kind_t k, int rot, int px, int py);
    if (px < int'(MIN_X[k][rot]) || px > int'(MAX_X[k][rot]) || py > int'(MAX_Y[k][rot]))
      return 1'b0;
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        if (cell_on(k, rot, r, c) && py + r >= HID && board[py+r-HID][px-2+c] != EMPTY)
          return 1'b0;
    return 1'b1;
  endfunction

  // field row counts the hidden rows
  function automatic logic covers(int row, int col);
    int r;
    int c;
    r = row - m_y;
    c = col - m_x + 2;
    return r >= 0 && r < 4 && c >= 0 && c < 4 && cell_on(m_kind, m_rot, r, c);
  endfunction

  function automatic kind_t cell_exp(logic [3:0] cx, logic [4:0] cy);
    if (int'(cx) >= W || int'(cy) >= H)
      return EMPTY;
    if (covers(int'(cy) + HID, int'(cx)))
      return m_kind;
    return board[cy][cx];
  endfunction

  function automatic logic [15:0] to_bcd(int n);
    logic [15:0] b;
    int v;
    v = n % 10000;
    for (int d = 0; d < 4; d++) begin
      b[4*d +: 4] = 4'(v % 10);
      v = v / 10;
    end
    return b;
  endfunction

  function automatic logic [3*`TETRIS_PREVIEW-1:0] preview_exp();
    logic [3*`TETRIS_PREVIEW-1:0] e;
    kind_t k;
    k = m_kind;
    for (int i = 0; i < `TETRIS_PREVIEW; i++) begin
      k = kind_after(k);
      e[3*i +: 3] = k;
    end
    return e;
  endfunction

  // states fixed by the command timing, NONE where the latency varies
  function automatic state_t step_exp(state_t first, int n);
    case (first)
      LEFT, RIGHT, ROTATE, ROTATE_REV:
        return (n == 1) ? first : (n == 2) ? MCHECK : (n == 3) ? WAIT : NONE;
      HOLD:
        return (n == 1) ? first : (n == 2) ? HCHECK : (n == 3) ? WAIT : NONE;
      DOWN:
        return (n == 1) ? first : (n == 2) ? DCHECK : NONE;
      DROP:
        return (n == 1) ? first : (n == 2) ? PCHECK : NONE;
      INIT:
        return (n == 1) ? INIT : (n == 2) ? GEN : (n == 3) ? WAIT : NONE;
      default:
        return (n == 1) ? GEN : (n == 2) ? WAIT : NONE;
    endcase
  endfunction

  task automatic spawn(kind_t k);
    m_kind = k;
    m_rot = 0;
    m_x = `TETRIS_SPAWN_X;
    m_y = 0;
  endtask

  task automatic new_game();
    for (int r = 0; r < H; r++)
      for (int c = 0; c < W; c++)
        board[r][c] = EMPTY;
    m_hold = EMPTY;
    m_lines = 0;
    m_over = 1'b0;
    spawn(kind_after(EMPTY));
  endtask

  task automatic land();
    int dst;
    logic full;
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        if (cell_on(m_kind, m_rot, r, c) && m_y + r < HID)
          m_over = 1'b1;
    if (m_over)
      return;  // still sticking out so the game is over
    for (int r = 0; r < 4; r++)
      for (int c = 0; c < 4; c++)
        if (cell_on(m_kind, m_rot, r, c))
          board[m_y+r-HID][m_x-2+c] = m_kind;
    dst = H - 1;
    for (int src = H - 1; src >= 0; src--) begin
      full = 1'b1;
      for (int c = 0; c < W; c++)
        if (board[src][c] == EMPTY)
          full = 1'b0;
      if (full) begin
        m_lines++;
      end else begin
        for (int c = 0; c < W; c++)
          board[dst][c] = board[src][c];
        dst--;
      end
    end
    for (int r = dst; r >= 0; r--)
      for (int c = 0; c < W; c++)
        board[r][c] = EMPTY;
    spawn(kind_after(m_kind));
  endtask

  task automatic apply(state_t c);
    kind_t sk;
    case (c)
      LEFT:       if (fits(m_kind, m_rot, m_x - 1, m_y)) m_x--;
      RIGHT:      if (fits(m_kind, m_rot, m_x + 1, m_y)) m_x++;
      ROTATE:     if (fits(m_kind, (m_rot + 1) % 4, m_x, m_y)) m_rot = (m_rot + 1) % 4;
      ROTATE_REV: if (fits(m_kind, (m_rot + 3) % 4, m_x, m_y)) m_rot = (m_rot + 3) % 4;
      DOWN: begin
        if (fits(m_kind, m_rot, m_x, m_y + 1))
          m_y++;
        else
          land();
      end
      DROP: begin
        while (fits(m_kind, m_rot, m_x, m_y + 1))
          m_y++;
        land();
      end
      HOLD: begin
        sk = (m_hold == EMPTY) ? kind_after(m_kind) : m_hold;
        if (fits(sk, 0, m_x, m_y)) begin
          m_hold = m_kind;
          m_kind = sk;
          m_rot = 0;
        end
      end
      default: new_game();
    endcase
  endtask

  task automatic check(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic arrive();
    if (!have_pend) begin
      errors++;
      test_errors++;
      $display("state reached %s without an accepted command", state.name());
    end else begin
      apply(pend);
      have_pend = 1'b0;
      m_live = 1'b1;
      check("state", 16'(state), 16'(m_over ? END : WAIT));
      check("score", score, to_bcd(m_lines));
      check("hold", 16'(hold), 16'(m_hold));
      check("next", 16'(next), 16'(preview_exp()));
    end
  endtask

  always @(posedge clk) begin
    if (reset_n) begin
      have_pend = 1'b0;
      rd_stable = 1'b0;
      m_live = 1'b0;
      acc_step = 0;
      last_state = INIT;
    end else begin
      if (rd_stable && m_live)
        check("kind", 16'(kind), 16'(cell_exp(rd_x, rd_y)));
      if (acc_step > 0) begin
        exp_st = step_exp(acc_first, acc_step);
        if (exp_st == NONE) begin
          acc_step = 0;
        end else begin
          check("state", 16'(state), 16'(exp_st));
          acc_step++;
        end
      end
      if ((state == WAIT || state == END) && !(last_state == WAIT || last_state == END))
        arrive();
      if (state == WAIT && ctrl inside {LEFT, RIGHT, ROTATE, ROTATE_REV, DOWN, DROP, HOLD}) begin
        pend = ctrl;
        have_pend = 1'b1;
        acc_first = ctrl;
        acc_step = 1;
      end
      if ((state == INIT || state == END) && ctrl != NONE) begin
        pend = INIT;  // new game
        have_pend = 1'b1;
        acc_first = (state == END) ? INIT : GEN;
        acc_step = 1;
      end
      rd_stable = (state == WAIT || state == END);
      rd_x = x;
      rd_y = y;
      last_state = state;
    end
  end

  task automatic report_test(string name);
    $display("test %-12s %6d checks %4d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("total %0d checks, %0d errors", checks, errors);
  endtask

endmodule

/* verilog/tetris_top.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module tetris_top import tetris_cmd_pkg::*, tetris_piece_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  state_t     ctrl,
  input  logic [3:0] x,
  input  logic [4:0] y,
  output state_t     state,
  output logic [4*`TETRIS_SCORE_DIGITS-1:0] score,
  output kind_t      kind,
  output kind_t      hold,
  output kind_t [`TETRIS_PREVIEW-1:0] next
);

  piece_op_t   op;
  field_mask_t cur_mask;
  field_mask_t cand_mask;
  kind_t       cur_kind;
  logic        valid;
  logic        in_bounds;
  logic        overlap;
  logic        outside;
  logic        row_full;
  logic        lock;
  logic        wipe;
  logic        clr_start;
  logic        clr_step;
  logic        line_done;

  tetris_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl      (ctrl),
    .in_bounds (in_bounds),
    .overlap   (overlap),
    .outside   (outside),
    .row_full  (row_full),
    .state     (state),
    .op        (op),
    .valid     (valid),
    .lock      (lock),
    .wipe      (wipe),
    .clr_start (clr_start),
    .clr_step  (clr_step),
    .line_done (line_done)
  );

  piece_move u_piece (
    .clk       (clk),
    .reset_n   (reset_n),
    .op        (op),
    .valid     (valid),
    .cur_mask  (cur_mask),
    .cand_mask (cand_mask),
    .cur_kind  (cur_kind),
    .hold      (hold),
    .next      (next),
    .in_bounds (in_bounds),
    .outside   (outside)
  );

  board_store u_board (
    .clk       (clk),
    .reset_n   (reset_n),
    .cand_mask (cand_mask),
    .cur_mask  (cur_mask),
    .cur_kind  (cur_kind),
    .lock      (lock),
    .wipe      (wipe),
    .clr_start (clr_start),
    .clr_step  (clr_step),
    .x         (x),
    .y         (y),
    .overlap   (overlap),
    .row_full  (row_full),
    .kind      (kind)
  );

  // new game clears the count together with the well
  bcd_score u_score (
    .clk       (clk),
    .reset_n   (reset_n),
    .restart   (wipe),
    .line_done (line_done),
    .score     (score)
  );

endmodule

/* verilog/bcd_score.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module bcd_score (
  input  logic clk,
  input  logic reset_n,
  input  logic restart,
  input  logic line_done,
  output logic [4*`TETRIS_SCORE_DIGITS-1:0] score
);

  logic [4*`TETRIS_SCORE_DIGITS-1:0] score_inc;
  logic                              carry;

  // ripple the +1 through the digits, 9 rolls to 0
  always_comb begin
    carry = 1'b1;
    for (int d = 0; d < `TETRIS_SCORE_DIGITS; d++) begin
      if (carry && score[4*d +: 4] == 4'd9) begin
        score_inc[4*d +: 4] = 4'd0;
      end else begin
        score_inc[4*d +: 4] = score[4*d +: 4] + {3'd0, carry};
        carry = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n || restart)
      score <= '0;
    else if (line_done)
      score <= score_inc;  // 9999 wraps to 0000
  end

endmodule

/* verilog/board_store.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module board_store import tetris_piece_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  field_mask_t cand_mask,
  input  field_mask_t cur_mask,
  input  kind_t       cur_kind,
  input  logic        lock,
  input  logic        wipe,
  input  logic        clr_start,
  input  logic        clr_step,
  input  logic [3:0]  x,
  input  logic [4:0]  y,
  output logic        overlap,
  output logic        row_full,
  output kind_t       kind
);

  localparam int BOARD_BITS = `TETRIS_W * `TETRIS_H;

  logic [2:0][BOARD_BITS-1:0] plane;       // one plane per kind bit
  logic [2:0][BOARD_BITS-1:0] collapsed;
  logic [BOARD_BITS-1:0]      placed;
  logic [BOARD_BITS-1:0]      test_mask;   // bottom row is the row under test
  logic [BOARD_BITS-1:0]      clear_mask;  // ones from the tested row upward
  logic [7:0]                 rd_addr;
  logic                       rd_ok;

  assign placed = plane[0] | plane[1] | plane[2];
  assign overlap = |(cand_mask[BOARD_BITS-1:0] & placed);
  assign row_full = &test_mask[`TETRIS_W-1:0];

  // rows from the tested one up take the row above them
  always_comb begin
    for (int b = 0; b < 3; b++)
      collapsed[b] = (plane[b] & ~clear_mask) | ((plane[b] >> `TETRIS_W) & clear_mask);
  end

  always_ff @(posedge clk) begin
    if (reset_n || wipe) begin
      plane <= '0;
    end else if (lock) begin
      for (int b = 0; b < 3; b++)
        plane[b] <= plane[b] | (cur_mask[BOARD_BITS-1:0] & {BOARD_BITS{cur_kind[b]}});
    end else if (clr_step && row_full) begin
      plane <= collapsed;
    end
  end

  always_ff @(posedge clk) begin
    if (clr_start) begin
      test_mask <= placed;
      clear_mask <= '1;
    end else if (clr_step) begin
      test_mask <= test_mask >> `TETRIS_W;
      clear_mask <= clear_mask << `TETRIS_W;
    end
  end

  // y=0 is the top visible row, x=0 the left column
  assign rd_ok = (x < 4'(`TETRIS_W)) && (y < 5'(`TETRIS_H));
  assign rd_addr = 8'((`TETRIS_H - 1 - y) * `TETRIS_W + (`TETRIS_W - 1 - x));

  always_ff @(posedge clk) begin
    if (!rd_ok)
      kind <= EMPTY;
    else if (cur_mask[rd_addr])
      kind <= cur_kind;  // falling piece drawn over the well
    else
      kind <= kind_t'({plane[2][rd_addr], plane[1][rd_addr], plane[0][rd_addr]});
  end

endmodule

/* verilog/piece_move.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module piece_move import tetris_cmd_pkg::*, tetris_piece_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  piece_op_t   op,
  input  logic        valid,
  output field_mask_t cur_mask,
  output field_mask_t cand_mask,
  output kind_t       cur_kind,
  output kind_t       hold,
  output kind_t [`TETRIS_PREVIEW-1:0] next,
  output logic        in_bounds,
  output logic        outside
);

  localparam int FIELD_BITS = $bits(field_mask_t);

  piece_pos_t  cur;
  piece_pos_t  cand;
  piece_pos_t  cand_nx;
  piece_pos_t  spawn_pos;
  field_mask_t shift_mask;
  field_mask_t table_mask;
  kind_t       swap_kind;
  logic        cand_hold;  // candidate came out of the hold slot

  function automatic kind_t kind_after(kind_t k);
    return (k == Z) ? I : kind_t'(k + 3'd1);
  endfunction

  // window drawn at x=2, y=0, then moved into place
  function automatic field_mask_t place(piece_pos_t p);
    field_mask_t m;
    logic [15:0] s;
    m = '0;
    s = SHAPE[p.kind][p.rot];
    for (int r = 0; r < 4; r++)
      m[FIELD_BITS-1-`TETRIS_W*r -: 4] = s[15-4*r -: 4];
    if (p.x >= 4'd2)
      m = m >> (p.x - 4'd2);
    else
      m = m << (4'd2 - p.x);
    return m >> (`TETRIS_W * p.y);
  endfunction

  assign cur_kind = cur.kind;
  assign swap_kind = (hold == EMPTY) ? kind_after(cur.kind) : hold;  // empty slot takes the next kind
  assign spawn_pos = '{kind: kind_after(cur.kind), rot: 2'd0, x: 4'(`TETRIS_SPAWN_X), y: 5'd0};

  always_comb begin
    cand_nx = cur;
    shift_mask = cur_mask;
    case (op)
      OP_LEFT: begin
        cand_nx.x = cur.x - 4'd1;
        shift_mask = cur_mask << 1;
      end
      OP_RIGHT: begin
        cand_nx.x = cur.x + 4'd1;
        shift_mask = cur_mask >> 1;
      end
      OP_DOWN: begin
        cand_nx.y = cur.y + 5'd1;
        shift_mask = cur_mask >> `TETRIS_W;
      end
      OP_ROT:     cand_nx.rot = cur.rot + 2'd1;
      OP_ROT_REV: cand_nx.rot = cur.rot - 2'd1;
      OP_HOLD: begin
        cand_nx.kind = swap_kind;
        cand_nx.rot = 2'd0;
      end
      default: ;
    endcase
  end

  assign table_mask = place(cand_nx);

  always_ff @(posedge clk) begin
    if (op inside {OP_LEFT, OP_RIGHT, OP_ROT, OP_ROT_REV, OP_DOWN, OP_HOLD}) begin
      cand <= cand_nx;
      cand_hold <= (op == OP_HOLD);
      if (op inside {OP_ROT, OP_ROT_REV, OP_HOLD})
        cand_mask <= table_mask;
      else
        cand_mask <= shift_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      cur <= '0;
      cur_mask <= '0;
      hold <= EMPTY;
    end else begin
      case (op)
        OP_CLEAR_ALL: begin
          cur <= '0;
          cur_mask <= '0;
          hold <= EMPTY;
        end
        OP_SPAWN: begin
          cur <= spawn_pos;
          cur_mask <= place(spawn_pos);
        end
        OP_COMMIT: begin
          if (valid) begin
            cur <= cand;
            cur_mask <= cand_mask;
            if (cand_hold)
              hold <= cur.kind;
          end
        end
        default: ;
      endcase
    end
  end

  assign in_bounds = MIN_X[cand.kind][cand.rot] <= cand.x &&
                     cand.x <= MAX_X[cand.kind][cand.rot] &&
                     cand.y <= MAX_Y[cand.kind][cand.rot];
  assign outside = |cur_mask[FIELD_BITS-1 -: `TETRIS_W*`TETRIS_HIDDEN];

  always_comb begin
    next[0] = kind_after(cur.kind);
    for (int i = 1; i < `TETRIS_PREVIEW; i++)
      next[i] = kind_after(next[i-1]);
  end

endmodule

/* verilog/tetris_ctrl.sv */
`timescale 1ns/10ps
`include "tetris_macros.svh"

module tetris_ctrl import tetris_cmd_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  state_t    ctrl,
  input  logic      in_bounds,
  input  logic      overlap,
  input  logic      outside,
  input  logic      row_full,
  output state_t    state,
  output piece_op_t op,
  output logic      valid,
  output logic      lock,
  output logic      wipe,
  output logic      clr_start,
  output logic      clr_step,
  output logic      line_done
);

  state_t     next_state;
  logic [4:0] row_cnt;    // row under test in the clear scan
  logic       scan_last;
  logic       restart;    // a command in END already asked for the next game

  assign valid = in_bounds && !overlap;
  assign scan_last = (row_cnt == 5'(`TETRIS_H - 1));

  always_comb begin
    next_state = state;
    case (state)
      INIT:
        if (ctrl != NONE || restart)
          next_state = GEN;
      GEN:
        next_state = WAIT;
      WAIT:
        if (ctrl inside {LEFT, RIGHT, ROTATE, ROTATE_REV, DOWN, DROP, HOLD})
          next_state = ctrl;
      LEFT, RIGHT, ROTATE, ROTATE_REV:
        next_state = MCHECK;
      DOWN:
        next_state = DCHECK;
      DROP:
        next_state = PCHECK;
      HOLD:
        next_state = HCHECK;
      MCHECK, HCHECK:
        next_state = WAIT;
      DCHECK, PCHECK: begin
        if (valid)
          next_state = (state == PCHECK) ? DROP : WAIT;  // hard drop keeps falling
        else if (outside)
          next_state = END;
        else
          next_state = CPREP;
      end
      CPREP:
        next_state = CLEAR;
      CLEAR: begin
        if (row_full)
          next_state = CPREP;  // rescan from the bottom after a collapse
        else if (scan_last)
          next_state = GEN;
      end
      END:
        if (ctrl != NONE)
          next_state = INIT;
      default:
        next_state = INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      state <= INIT;
      row_cnt <= '0;
      restart <= 1'b0;
    end else begin
      state <= next_state;
      if (state == CPREP)
        row_cnt <= '0;
      else if (state == CLEAR)
        row_cnt <= row_cnt + 5'd1;
      if (state == END)
        restart <= (ctrl != NONE);
      else if (state == GEN)
        restart <= 1'b0;
    end
  end

  always_comb begin
    case (state)
      INIT:                        op = OP_CLEAR_ALL;
      GEN:                         op = OP_SPAWN;
      LEFT:                        op = OP_LEFT;
      RIGHT:                       op = OP_RIGHT;
      ROTATE:                      op = OP_ROT;
      ROTATE_REV:                  op = OP_ROT_REV;
      DOWN, DROP:                  op = OP_DOWN;
      HOLD:                        op = OP_HOLD;
      MCHECK, DCHECK, PCHECK, HCHECK: op = OP_COMMIT;
      default:                     op = OP_IDLE;
    endcase
  end

  // a blocked fall inside the well locks the piece
  assign lock = (state == DCHECK || state == PCHECK) && !valid && !outside;
  assign wipe = (state == INIT);
  assign clr_start = (state == CPREP);
  assign clr_step = (state == CLEAR);
  assign line_done = (state == CLEAR) && row_full;

endmodule

/* verilog/tetris_piece_pkg.sv */
`include "tetris_macros.svh"

package tetris_piece_pkg;

  typedef enum logic [2:0] {
    EMPTY,
    I,
    J,
    L,
    O,
    S,
    T,
    Z
  } kind_t;

  typedef struct packed {
    kind_t      kind;
    logic [1:0] rot;
    logic [3:0] x;  // window column x-2 is the left edge
    logic [4:0] y;  // top row of the window, 0 is the top hidden row
  } piece_pos_t;

  // 22 rows of 10 cells, bit 0 is the bottom right cell
  typedef logic [`TETRIS_W*(`TETRIS_H+`TETRIS_HIDDEN)-1:0] field_mask_t;

  // [kind][rot], four rows of the 4x4 window, top row in bits 15:12
  localparam logic [15:0] SHAPE [8][4] = '{
    '{16'h0000, 16'h0000, 16'h0000, 16'h0000},  // empty
    '{16'h0F00, 16'h2222, 16'h00F0, 16'h4444},  // I
    '{16'h8E00, 16'h6440, 16'h0E20, 16'h44C0},  // J
    '{16'h2E00, 16'h4460, 16'h0E80, 16'hC440},  // L
    '{16'h6600, 16'h6600, 16'h6600, 16'h6600},  // O
    '{16'h6C00, 16'h4620, 16'h06C0, 16'h8C40},  // S
    '{16'h4E00, 16'h4640, 16'h0E40, 16'h4C40},  // T
    '{16'hC600, 16'h2640, 16'h0C60, 16'h4C80}   // Z
  };

  // legal x range per kind and rotation, empty never fits
  localparam logic [3:0] MIN_X [8][4] = '{
    '{4'd15, 4'd15, 4'd15, 4'd15},
    '{4'd2, 4'd0, 4'd2, 4'd1},
    '{4'd2, 4'd1, 4'd2, 4'd2},
    '{4'd2, 4'd1, 4'd2, 4'd2},
    '{4'd1, 4'd1, 4'd1, 4'd1},
    '{4'd2, 4'd1, 4'd2, 4'd2},
    '{4'd2, 4'd1, 4'd2, 4'd2},
    '{4'd2, 4'd1, 4'd2, 4'd2}
  };

  localparam logic [3:0] MAX_X [8][4] = '{
    '{4'd0, 4'd0, 4'd0, 4'd0},
    '{4'd8, 4'd9, 4'd8, 4'd10},
    '{4'd9, 4'd9, 4'd9, 4'd10},
    '{4'd9, 4'd9, 4'd9, 4'd10},
    '{4'd9, 4'd9, 4'd9, 4'd9},
    '{4'd9, 4'd9, 4'd9, 4'd10},
    '{4'd9, 4'd9, 4'd9, 4'd10},
    '{4'd9, 4'd9, 4'd9, 4'd10}
  };

  // lowest legal window top row
  localparam logic [4:0] MAX_Y [8][4] = '{
    '{5'd0, 5'd0, 5'd0, 5'd0},
    '{5'd20, 5'd18, 5'd19, 5'd18},
    '{5'd20, 5'd19, 5'd19, 5'd19},
    '{5'd20, 5'd19, 5'd19, 5'd19},
    '{5'd20, 5'd20, 5'd20, 5'd20},
    '{5'd20, 5'd19, 5'd19, 5'd19},
    '{5'd20, 5'd19, 5'd19, 5'd19},
    '{5'd20, 5'd19, 5'd19, 5'd19}
  };

endpackage

/* verilog/tetris_cmd_pkg.sv */
package tetris_cmd_pkg;

  // host commands sit at the bottom so NONE is zero
  typedef enum logic [4:0] {
    NONE,
    LEFT,
    RIGHT,
    ROTATE,
    ROTATE_REV,
    DOWN,
    DROP,
    HOLD,
    INIT,
    GEN,
    WAIT,
    MCHECK,
    DCHECK,
    PCHECK,
    HCHECK,
    CPREP,
    CLEAR,
    END
  } state_t;

  // what piece_move builds or commits this cycle
  typedef enum logic [3:0] {
    OP_IDLE,
    OP_CLEAR_ALL,
    OP_SPAWN,
    OP_LEFT,
    OP_RIGHT,
    OP_ROT,
    OP_ROT_REV,
    OP_DOWN,
    OP_HOLD,
    OP_COMMIT
  } piece_op_t;

endpackage

/* include/tetris_macros.svh */
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// well size in cells
`define TETRIS_W 10
`define TETRIS_H 20

// rows above the well where pieces spawn
`define TETRIS_HIDDEN 2

// centre column of a new piece, window spans x-2 .. x+1
`define TETRIS_SPAWN_X 5

`define TETRIS_PREVIEW 4       // kinds shown ahead
`define TETRIS_SCORE_DIGITS 4  // bcd digits of the line count

`endif
